/* bench/cache_subsystem_tb.sv */
`timescale 1ns/1ps

module cache_subsystem_tb;

    localparam int latency      = 4;
    localparam int hit_delay    = 0;
    localparam int clean_delay  = latency + 1;
    localparam int dirty_delay  = 2 * latency + 1;
    localparam int any_delay    = -1;               // Only the upper bound applies
    localparam int reset_cycles = 5;
    localparam int random_ops   = 200;
    localparam int num_requests = 2 + 6 + 6 + 4 + random_ops;
    localparam int cycle_limit  = 40 * num_requests + reset_cycles;

    logic                     clk;
    logic                     rst_n;
    lc3b_cache_pkg::cpu_req_t cpu_req;
    lc3b_cache_pkg::lc3b_word mem_rdata;
    logic                     mem_resp;

    logic [15:0] shadow [32768];                    // One entry per 16-bit word
    logic [31:0] lfsr;
    int          passes;
    int          errors;
    int          cycle_count;

    cache_subsystem #(.latency(latency)) i_cache_subsystem (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_req   (cpu_req),
        .mem_rdata (mem_rdata),
        .mem_resp  (mem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles with requests still pending", cycle_count);
            $display("sim failed");
            $finish;
        end
    end

    // The cache may only answer a request that is present
    always @(posedge clk) begin
        if (rst_n && !cpu_req.read && !cpu_req.write) begin
            assert (!mem_resp) begin
                passes++;
            end else begin
                $display("mem_resp was raised with no request present");
                errors++;
            end
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[14:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic logic [15:0] make_addr(input logic [8:0] tag, input logic [2:0] index,
                                              input logic [3:0] offset);
        return {tag, index, offset};
    endfunction

    task automatic check_value(input string name, input logic [15:0] addr,
                               input logic [15:0] expected, input logic [15:0] actual);
        assert (actual === expected) begin
            passes++;
        end else begin
            $display("FAILED %s at 0x%h: expected 0x%h, got 0x%h", name, addr, expected, actual);
            errors++;
        end
    endtask

    task automatic check_delay(input string what, input logic [15:0] addr,
                               input int expected, input int actual);
        if (expected < 0) begin
            assert (actual <= dirty_delay) begin
                passes++;
            end else begin
                $display("%s of 0x%h took %0d cycles, more than the %0d allowed",
                         what, addr, actual, dirty_delay);
                errors++;
            end
        end else begin
            assert (actual == expected) begin
                passes++;
            end else begin
                $display("%s of 0x%h was answered after %0d cycles instead of %0d",
                         what, addr, actual, expected);
                errors++;
            end
        end
    endtask

    // Holds the request from a falling edge until mem_resp is seen at a rising edge
    task automatic access(input logic write, input logic [15:0] addr, input logic [15:0] wdata,
                          input logic [1:0] be, output logic [15:0] rdata, output int delay);
        @(negedge clk);
        cpu_req.read        = ~write;
        cpu_req.write       = write;
        cpu_req.address     = addr;
        cpu_req.wdata       = wdata;
        cpu_req.byte_enable = be;
        delay = 0;
        @(posedge clk);
        while (!mem_resp) begin
            delay++;
            @(posedge clk);
        end
        rdata = mem_rdata;
        if (write && be[0]) begin
            shadow[addr[15:1]][7:0] = wdata[7:0];      // Even byte sits in the low half
        end
        if (write && be[1]) begin
            shadow[addr[15:1]][15:8] = wdata[15:8];
        end
        @(negedge clk);
        cpu_req = '0;
    endtask

    task automatic read_expect(input logic [15:0] addr, input int exp_delay);
        logic [15:0] rdata;
        int          delay;
        access(1'b0, addr, 16'h0000, 2'b00, rdata, delay);
        check_value("mem_rdata", addr, shadow[addr[15:1]], rdata);
        check_delay("read", addr, exp_delay, delay);
    endtask

    task automatic write_expect(input logic [15:0] addr, input logic [15:0] wdata,
                                input logic [1:0] be, input int exp_delay);
        logic [15:0] rdata;
        int          delay;
        access(1'b1, addr, wdata, be, rdata, delay);
        check_delay("write", addr, exp_delay, delay);
    endtask

    task automatic report_test(input int num, input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - errors_before);
        end
    endtask

    initial begin
        logic [15:0] line_a;
        logic [15:0] data;
        logic [15:0] op_bit;
        logic [15:0] tag_sel;
        logic [15:0] idx_sel;
        logic [15:0] word_sel;
        logic [15:0] be_bits;
        logic [15:0] addr;
        int          mark;

        cpu_req     = '0;
        rst_n       = 1'b0;
        lfsr        = 32'd82132;
        passes      = 0;
        errors      = 0;
        cycle_count = 0;
        for (int w = 0; w < 32768; w++) begin
            shadow[w] = 16'(w * 2) ^ 16'hA5C3;           // Same scramble as main memory
        end
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        mark = errors;
        repeat (8) @(posedge clk);
        report_test(1, "idle after reset", mark);

        mark   = errors;
        line_a = make_addr(9'h024, 3'd3, 4'h6);
        read_expect(line_a, clean_delay);
        read_expect(line_a, hit_delay);
        report_test(2, "read miss then hit", mark);

        mark = errors;
        take_bits(16, data);
        write_expect(make_addr(9'h024, 3'd3, 4'h2), data, 2'b01, hit_delay);
        take_bits(16, data);
        write_expect(make_addr(9'h024, 3'd3, 4'h8), data, 2'b10, hit_delay);
        take_bits(16, data);
        write_expect(make_addr(9'h024, 3'd3, 4'h6), data, 2'b11, hit_delay);
        read_expect(make_addr(9'h024, 3'd3, 4'h2), hit_delay);
        read_expect(make_addr(9'h024, 3'd3, 4'h8), hit_delay);
        read_expect(make_addr(9'h024, 3'd3, 4'h6), hit_delay);
        report_test(3, "byte-masked write hits", mark);

        mark = errors;
        read_expect(make_addr(9'h010, 3'd2, 4'h0), clean_delay);   // Tag A
        read_expect(make_addr(9'h021, 3'd2, 4'h4), clean_delay);   // Tag B
        read_expect(make_addr(9'h010, 3'd2, 4'hA), hit_delay);
        read_expect(make_addr(9'h1F3, 3'd2, 4'hC), clean_delay);   // Tag C replaces B
        read_expect(make_addr(9'h010, 3'd2, 4'h2), hit_delay);
        read_expect(make_addr(9'h021, 3'd2, 4'h4), clean_delay);
        report_test(4, "LRU replacement", mark);

        mark = errors;
        take_bits(16, data);
        write_expect(make_addr(9'h055, 3'd5, 4'hE), data, 2'b11, clean_delay);
        read_expect(make_addr(9'h0AA, 3'd5, 4'h0), clean_delay);
        read_expect(make_addr(9'h133, 3'd5, 4'h0), dirty_delay);   // Victim is the dirty line
        read_expect(make_addr(9'h055, 3'd5, 4'hE), clean_delay);
        report_test(5, "dirty eviction and writeback", mark);

        mark = errors;
        for (int n = 0; n < random_ops; n++) begin
            take_bits(1, op_bit);
            take_bits(2, tag_sel);
            take_bits(1, idx_sel);
            take_bits(3, word_sel);
            take_bits(2, be_bits);
            take_bits(16, data);
            // Four tags over sets 6 and 7 keep evictions frequent
            addr = make_addr({7'h0A, tag_sel[1:0]}, {2'b11, idx_sel[0]}, {word_sel[2:0], 1'b0});
            if (op_bit[0]) begin
                write_expect(addr, data, be_bits[1:0], any_delay);
            end else begin
                read_expect(addr, any_delay);
            end
        end
        report_test(6, "random reads and writes", mark);

        $display("checks: %0d passed, %0d failed", passes, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* hw/cache_control.sv */
`timescale 1ns/1ps

module cache_control (
    input  logic                          clk,
    input  logic                          rst_n,
    input  lc3b_cache_pkg::cpu_req_t      cpu_req,
    input  lc3b_cache_pkg::cache_status_t status,
    input  lc3b_cache_pkg::lc3b_c_tag     victim_tag,
    input  logic                          pmem_resp,
    output lc3b_cache_pkg::cache_ctrl_t   ctrl,
    output logic                          pmem_read,
    output logic                          pmem_write,
    output lc3b_cache_pkg::lc3b_word      pmem_address,
    output logic                          mem_resp
);

    lc3b_cache_pkg::cache_state_e state;
    lc3b_cache_pkg::cache_state_e next_state;
    logic                         request;

    assign request = cpu_req.read | cpu_req.write;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= lc3b_cache_pkg::s_check;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state   = state;
        ctrl         = '0;
        mem_resp     = 1'b0;
        pmem_read    = 1'b0;
        pmem_write   = 1'b0;
        pmem_address = {cpu_req.address[15:4], 4'h0};   // Line holding the request

        case (state)
            lc3b_cache_pkg::s_check: begin
                if (request && status.hit) begin
                    mem_resp    = 1'b1;
                    ctrl.ld_lru = 1'b1;
                    if (cpu_req.write) begin
                        ctrl.ld_word   = 1'b1;
                        ctrl.set_dirty = 1'b1;
                    end
                end else if (request) begin
                    next_state = status.victim_dirty ? lc3b_cache_pkg::s_writeback
                                                     : lc3b_cache_pkg::s_allocate;
                end
            end

            lc3b_cache_pkg::s_writeback: begin
                pmem_write   = 1'b1;
                pmem_address = {victim_tag, cpu_req.address[6:4], 4'h0};  // Victim's line
                if (pmem_resp) begin
                    next_state = lc3b_cache_pkg::s_allocate;
                end
            end

            lc3b_cache_pkg::s_allocate: begin
                pmem_read = 1'b1;
                if (pmem_resp) begin
                    ctrl.ld_fill   = 1'b1;
                    ctrl.clr_dirty = 1'b1;   // A fresh line matches memory
                    next_state     = lc3b_cache_pkg::s_check;
                end
            end

            default: begin
                next_state = lc3b_cache_pkg::s_check;
            end
        endcase
    end

endmodule

/* hw/cache_datapath.sv */
`timescale 1ns/1ps

module cache_datapath (
    input  logic                          clk,
    input  logic                          rst_n,
    input  lc3b_cache_pkg::cpu_req_t      cpu_req,
    input  lc3b_cache_pkg::cache_ctrl_t   ctrl,
    input  lc3b_cache_pkg::lc3b_mem_data  pmem_rdata,
    output lc3b_cache_pkg::cache_status_t status,
    output lc3b_cache_pkg::lc3b_c_tag     victim_tag,
    output lc3b_cache_pkg::lc3b_mem_data  victim_line,
    output lc3b_cache_pkg::lc3b_word      mem_rdata
);

    lc3b_cache_pkg::lc3b_c_tag    tag;
    lc3b_cache_pkg::lc3b_c_index  index;
    lc3b_cache_pkg::lc3b_c_offset offset;
    lc3b_cache_pkg::lc3b_c_tag    tag0_out;
    lc3b_cache_pkg::lc3b_c_tag    tag1_out;
    lc3b_cache_pkg::lc3b_mem_data data0_out;
    lc3b_cache_pkg::lc3b_mem_data data1_out;
    lc3b_cache_pkg::lc3b_mem_data hit_line;
    lc3b_cache_pkg::lc3b_mem_data merged_line;
    lc3b_cache_pkg::lc3b_mem_data data_in;
    logic valid0_out;
    logic valid1_out;
    logic dirty0_out;
    logic dirty1_out;
    logic lru_out;
    logic hit0;
    logic hit1;
    logic wr_way;
    logic fill0;
    logic fill1;
    logic ld_data0;
    logic ld_data1;
    logic ld_dirty0;
    logic ld_dirty1;

    assign tag    = cpu_req.address[15:7];
    assign index  = cpu_req.address[6:4];
    assign offset = cpu_req.address[3:0];

    assign hit0 = valid0_out & (tag0_out == tag);
    assign hit1 = valid1_out & (tag1_out == tag);

    // The LRU bit names the way to replace next
    assign fill0  = ctrl.ld_fill & ~lru_out;
    assign fill1  = ctrl.ld_fill & lru_out;
    assign wr_way = ctrl.ld_fill ? lru_out : hit1;

    assign ld_data0  = fill0 | (ctrl.ld_word & hit0);
    assign ld_data1  = fill1 | (ctrl.ld_word & hit1);
    assign ld_dirty0 = (ctrl.set_dirty | ctrl.clr_dirty) & ~wr_way;
    assign ld_dirty1 = (ctrl.set_dirty | ctrl.clr_dirty) & wr_way;

    assign hit_line = hit1 ? data1_out : data0_out;
    assign data_in  = ctrl.ld_fill ? pmem_rdata : merged_line;

    assign victim_tag          = lru_out ? tag1_out : tag0_out;
    assign victim_line         = lru_out ? data1_out : data0_out;
    assign status.hit          = hit0 | hit1;
    assign status.victim_dirty = lru_out ? dirty1_out : dirty0_out;

    set_array #(.width(9)) tag0 (.clk, .rst_n, .load(fill0), .index,
        .in(tag), .out(tag0_out));
    set_array #(.width(9)) tag1 (.clk, .rst_n, .load(fill1), .index,
        .in(tag), .out(tag1_out));
    set_array #(.width(1)) valid0 (.clk, .rst_n, .load(fill0), .index,
        .in(1'b1), .out(valid0_out));
    set_array #(.width(1)) valid1 (.clk, .rst_n, .load(fill1), .index,
        .in(1'b1), .out(valid1_out));
    set_array #(.width(1)) dirty0 (.clk, .rst_n, .load(ld_dirty0), .index,
        .in(ctrl.set_dirty), .out(dirty0_out));
    set_array #(.width(1)) dirty1 (.clk, .rst_n, .load(ld_dirty1), .index,
        .in(ctrl.set_dirty), .out(dirty1_out));
    set_array #(.width(1)) lru (.clk, .rst_n, .load(ctrl.ld_lru), .index,
        .in(~hit1), .out(lru_out));        // Point away from the way just used
    set_array #(.width(128)) data0 (.clk, .rst_n, .load(ld_data0), .index,
        .in(data_in), .out(data0_out));
    set_array #(.width(128)) data1 (.clk, .rst_n, .load(ld_data1), .index,
        .in(data_in), .out(data1_out));

    line_word_path i_line_word_path (
        .line        (hit_line),
        .offset      (offset),
        .wdata       (cpu_req.wdata),
        .byte_enable (cpu_req.byte_enable),
        .word        (mem_rdata),
        .merged      (merged_line)
    );

endmodule

/* hw/cache_subsystem.sv */
`timescale 1ns/1ps

module cache_subsystem #(
    parameter int latency = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  lc3b_cache_pkg::cpu_req_t cpu_req,
    output lc3b_cache_pkg::lc3b_word mem_rdata,
    output logic                     mem_resp
);

    lc3b_cache_pkg::cache_ctrl_t   ctrl;
    lc3b_cache_pkg::cache_status_t status;
    lc3b_cache_pkg::lc3b_c_tag     victim_tag;
    lc3b_cache_pkg::lc3b_mem_data  victim_line;
    lc3b_cache_pkg::lc3b_mem_data  pmem_rdata;
    lc3b_cache_pkg::lc3b_word      pmem_address;
    lc3b_cache_pkg::pmem_req_t     pmem_req;
    logic                          pmem_read;
    logic                          pmem_write;
    logic                          pmem_resp;

    // Writeback data is always the victim line
    assign pmem_req = '{read: pmem_read, write: pmem_write,
                        address: pmem_address, wdata: victim_line};

    cache_control i_cache_control (
        .clk, .rst_n, .cpu_req, .status, .victim_tag, .pmem_resp,
        .ctrl, .pmem_read, .pmem_write, .pmem_address, .mem_resp
    );

    cache_datapath i_cache_datapath (
        .clk, .rst_n, .cpu_req, .ctrl, .pmem_rdata,
        .status, .victim_tag, .victim_line, .mem_rdata
    );

    line_memory #(.latency(latency)) i_line_memory (
        .clk        (clk),
        .rst_n      (rst_n),
        .pmem_req   (pmem_req),
        .pmem_rdata (pmem_rdata),
        .pmem_resp  (pmem_resp)
    );

endmodule

/* hw/lc3b_cache_pkg.sv */
package lc3b_cache_pkg;

    typedef logic [15:0]  lc3b_word;
    typedef logic [8:0]   lc3b_c_tag;     // Address bits 15..7
    typedef logic [2:0]   lc3b_c_index;   // Address bits 6..4
    typedef logic [3:0]   lc3b_c_offset;  // Address bits 3..0
    typedef logic [1:0]   lc3b_mem_wmask;
    typedef logic [127:0] lc3b_mem_data;  // Eight words per line

    // Processor request, held by the processor until mem_resp
    typedef struct packed {
        logic          read;
        logic          write;
        lc3b_word      address;
        lc3b_word      wdata;
        lc3b_mem_wmask byte_enable;
    } cpu_req_t;

    typedef struct packed {
        logic         read;
        logic         write;
        lc3b_word     address;            // Always line aligned
        lc3b_mem_data wdata;
    } pmem_req_t;

    typedef struct packed {
        logic ld_fill;                    // Load victim way from the fill line
        logic ld_word;                    // Load merged word into the hit way
        logic set_dirty;
        logic clr_dirty;
        logic ld_lru;
    } cache_ctrl_t;

    typedef struct packed {
        logic hit;
        logic victim_dirty;
    } cache_status_t;

    typedef enum logic [1:0] {
        s_check,
        s_writeback,
        s_allocate
    } cache_state_e;

endpackage

/* hw/line_memory.sv */
`timescale 1ns/1ps

module line_memory #(
    parameter int latency = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  lc3b_cache_pkg::pmem_req_t    pmem_req,
    output lc3b_cache_pkg::lc3b_mem_data pmem_rdata,
    output logic                         pmem_resp
);

    localparam int lines = 4096;

    lc3b_cache_pkg::lc3b_mem_data store [lines];
    logic [11:0]                  line_addr;
    logic                         request;
    logic                         start;
    logic                         busy;
    logic                         done;

    assign line_addr = pmem_req.address[15:4];
    assign request   = pmem_req.read | pmem_req.write;
    assign start     = request & ~busy;      // First cycle of a new request

    pmem_timer #(.latency(latency)) i_pmem_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .busy  (busy),
        .done  (done)
    );

    // Each word holds its own byte address scrambled by a fixed pattern
    initial begin
        for (int l = 0; l < lines; l++) begin
            for (int w = 0; w < 8; w++) begin
                store[l][w*16 +: 16] = 16'(l * 16 + w * 2) ^ 16'hA5C3;
            end
        end
    end

    always @(posedge clk) begin
        if (done && pmem_req.write) begin
            store[line_addr] <= pmem_req.wdata;
        end
    end

    assign pmem_rdata = store[line_addr];    // Valid with the pmem_resp pulse
    assign pmem_resp  = done;

endmodule

/* hw/line_word_path.sv */
`timescale 1ns/1ps

module line_word_path (
    input  lc3b_cache_pkg::lc3b_mem_data  line,
    input  lc3b_cache_pkg::lc3b_c_offset  offset,
    input  lc3b_cache_pkg::lc3b_word      wdata,
    input  lc3b_cache_pkg::lc3b_mem_wmask byte_enable,
    output lc3b_cache_pkg::lc3b_word      word,
    output lc3b_cache_pkg::lc3b_mem_data  merged
);

    logic [2:0]  word_sel;
    logic [6:0]  word_base;
    logic [15:0] byte_mask;

    assign word_sel  = offset[3:1];              // Byte bit 0 picks nothing on a word bus
    assign word_base = {word_sel, 4'b0000};      // Bit position of the addressed word

    assign word = line[word_base +: 16];

    // One mask bit per byte of the line, set only for enabled bytes of the addressed word
    always_comb begin
        byte_mask = '0;
        for (int b = 0; b < 16; b++) begin
            if (b[3:1] == word_sel) begin
                byte_mask[b] = byte_enable[b[0]];
            end
        end
    end

    always_comb begin
        merged = line;
        for (int b = 0; b < 16; b++) begin
            if (byte_mask[b]) begin
                merged[b*8 +: 8] = wdata[b[0]*8 +: 8];   // Low byte to even address
            end
        end
    end

endmodule

/* hw/pmem_timer.sv */
`timescale 1ns/1ps

module pmem_timer #(
    parameter int latency = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic busy,
    output logic done
);

    localparam int cw = $clog2(latency) + 1;

    logic [cw-1:0] count;
    logic [cw-1:0] remaining;
    logic          active;

    // The start cycle counts as the first cycle of the access
    assign active    = busy | start;
    assign remaining = busy ? count : cw'(latency - 1);
    assign done      = active & (remaining == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            count <= '0;
        end else begin
            busy <= active & ~done;          // Idle again right after the pulse
            if (active && !done) begin
                count <= remaining - 1'b1;
            end
        end
    end

endmodule

/* hw/set_array.sv */
`timescale 1ns/1ps

module set_array #(
    parameter int width = 1
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        load,
    input  lc3b_cache_pkg::lc3b_c_index index,
    input  logic [width-1:0]            in,
    output logic [width-1:0]            out
);

    localparam int depth = 2 ** $bits(lc3b_cache_pkg::lc3b_c_index);

    logic [width-1:0] entry [depth];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) begin
                entry[i] <= '0;
            end
        end else if (load) begin
            entry[index] <= in;          // Visible on the read port after the edge
        end
    end

    assign out = entry[index];

endmodule

/* vlog.f */
hw/lc3b_cache_pkg.sv
hw/set_array.sv
hw/line_word_path.sv
hw/cache_datapath.sv
hw/cache_control.sv
hw/pmem_timer.sv
hw/line_memory.sv
hw/cache_subsystem.sv
bench/cache_subsystem_tb.sv
